/* files.f */
hw/mixer_pkg.sv
hw/mix_sequencer.sv
hw/mix_mac.sv
hw/mix_output.sv
hw/audio_mixer_top.sv
verif/mixer_checker.sv
verif/mixer_scoreboard.sv
verif/tb_audio_mixer.sv

/* Makefile */
VERILATOR := verilator
TOP       := tb_audio_mixer
FILELIST  := files.f
VFLAGS    := --binary --timing --assert -Wno-fatal
RUNFLAGS  := +verilator+error+limit+1000
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FILELIST))
FAIL_MSG  := FAIL: see errors above
PASS_MSG  := PASS: all tests

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUNFLAGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported a failure"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a verdict"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verif/mixer_patterns.txt */
# Columns are slot samples s0 s1 s2 s3 then volumes v0 v1 v2 v3 in hex
# Even slots feed the left sum and odd slots the right sum
100000 000000 000000 000000 FFFF FFFF FFFF FFFF
000000 400000 000000 000000 FFFF FFFF FFFF FFFF
000000 000000 F00000 000000 FFFF FFFF FFFF FFFF
000000 000000 000000 123456 0000 0000 0000 8000
100000 F80000 050000 020000 8000 C000 FFFF 4000
F00000 0A0000 FE0000 F40000 FFFF 8000 C000 FFFF
7FFFFF 700000 7FFFFF 700000 FFFF FFFF FFFF FFFF
800000 900000 800000 900000 FFFF FFFF FFFF FFFF
7F0000 810000 7F0000 810000 FFFF FFFF FFFF FFFF
7FFFFF 800000 123456 ABCDEF 0000 0000 0000 0000
000001 FFFFFF 000010 FFFFF0 FFFF FFFF FFFF FFFF
3A5C21 C4B7E9 0F1E2D E1D2C3 7A5B 9C3D 5E6F A1B2
000000 000000 000000 000000 FFFF FFFF FFFF FFFF
654321 9ABCDF 234567 DCBA98 FFFF FFFF 0001 8001

/* verif/tb_audio_mixer.sv */
`timescale 1ns/1ps

module tb_audio_mixer;

    import mixer_pkg::*;

    localparam int NUM_CH   = 2;
    localparam int FS       = 32;
    localparam int NSLOT    = 2 * NUM_CH;
    localparam int MAX_ROWS = 64;

    logic                clk;
    logic                rst;
    sample_t [NSLOT-1:0] data;
    vol_t    [NSLOT-1:0] vol;
    logic [NSLOT-1:0]    pop;
    sample_t             data_out;
    logic                lrck;
    logic                we;

    // Rows handed to the scoreboard
    sample_t [NSLOT-1:0] row_data;
    vol_t    [NSLOT-1:0] row_vol;
    logic                row_push;

    sample_t [NSLOT-1:0] pat_data [MAX_ROWS];
    vol_t    [NSLOT-1:0] pat_vol  [MAX_ROWS];
    int num_rows;
    int tb_errors;
    int sb_errors;
    int words_checked;
    int cycles = 0;
    int cycle_limit = 0;
    logic timed_out = 1'b0;

    audio_mixer_top #(
        .NUM_CH (NUM_CH),
        .FS     (FS)
    ) uut (
        .clk    (clk),
        .rst    (rst),
        .data_i (data),
        .vol_i  (vol),
        .pop_o  (pop),
        .data_o (data_out),
        .lrck_o (lrck),
        .we_o   (we)
    );

    mixer_scoreboard #(
        .NUM_CH (NUM_CH)
    ) u_sb (
        .clk        (clk),
        .rst        (rst),
        .row_data_i (row_data),
        .row_vol_i  (row_vol),
        .row_push_i (row_push),
        .pop_i      (pop),
        .data_i     (data_out),
        .lrck_i     (lrck),
        .we_i       (we),
        .errors_o   (sb_errors),
        .words_o    (words_checked)
    );

    bind audio_mixer_top mixer_checker #(
        .NUM_CH (NUM_CH)
    ) u_chk (
        .clk    (clk),
        .rst    (rst),
        .pop_i  (pop_o),
        .we_i   (we_o),
        .lrck_i (lrck_o)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // Four samples then four volumes per row
    task automatic read_patterns();
        int fd;
        int n;
        int k;
        string line;
        logic [SAMPLE_W-1:0] s [NSLOT];
        logic [VOL_W-1:0]    v [NSLOT];
        num_rows = 0;
        fd = $fopen("verif/mixer_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open verif/mixer_patterns.txt");
            tb_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                            s[0], s[1], s[2], s[3], v[0], v[1], v[2], v[3]);
                if (n == 2 * NSLOT && num_rows < MAX_ROWS) begin
                    for (k = 0; k < NSLOT; k++) begin
                        pat_data[num_rows][k] = s[k];
                        pat_vol[num_rows][k]  = v[k];
                    end
                    num_rows++;
                end
            end
            $fclose(fd);
        end
    endtask

    // Each slot moves to the next row once the DUT has popped it
    task automatic run_frames();
        int k;
        int cur_row [NSLOT];
        logic [NSLOT-1:0] seen;
        cycle_limit = (num_rows + 2) * FS + 50;
        for (k = 0; k < NSLOT; k++) begin
            data[k] = pat_data[0][k];
            vol[k]  = pat_vol[0][k];
            cur_row[k] = 0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        row_data = pat_data[0];
        row_vol  = pat_vol[0];
        row_push = 1'b1;
        while (words_checked < 2 * num_rows) begin
            @(posedge clk);
            seen = pop;
            #1;
            row_push = 1'b0;
            for (k = 0; k < NSLOT; k++) begin
                if (seen[k]) begin
                    cur_row[k]++;
                    if (cur_row[k] < num_rows) begin
                        data[k] = pat_data[cur_row[k]][k];
                        vol[k]  = pat_vol[cur_row[k]][k];
                    end
                    // Last slot of a frame hands the next row over
                    if (k == NSLOT - 1 && cur_row[k] < num_rows) begin
                        row_data = pat_data[cur_row[k]];
                        row_vol  = pat_vol[cur_row[k]];
                        row_push = 1'b1;
                    end
                end
            end
        end
    endtask

    task automatic finish_run();
        int assert_errors;
        int total;
        assert_errors = uut.u_chk.fail_count;
        total = sb_errors + assert_errors + tb_errors + (timed_out ? 1 : 0);
        $display("Words checked %0d, errors %0d (scoreboard %0d, assertions %0d, testbench %0d)",
                 words_checked, total, sb_errors, assert_errors, tb_errors + timed_out);
        if (total == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    initial begin
        rst = 1'b1;
        data = '0;
        vol = '0;
        row_data = '0;
        row_vol = '0;
        row_push = 1'b0;
        tb_errors = 0;
        read_patterns();
        if (num_rows == 0) begin
            $display("No pattern rows were read");
            tb_errors++;
            finish_run();
        end else begin
            run_frames();
            finish_run();
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Run timed out after %0d cycles with %0d of %0d words seen",
                     cycles, words_checked, 2 * num_rows);
            timed_out = 1'b1;
            finish_run();
        end
    end

endmodule

/* verif/mixer_scoreboard.sv */
`timescale 1ns/1ps

module mixer_scoreboard #(
    parameter int NUM_CH = 2
) (
    input  logic                                clk,
    input  logic                                rst,
    input  mixer_pkg::sample_t [2*NUM_CH-1:0]   row_data_i,
    input  mixer_pkg::vol_t    [2*NUM_CH-1:0]   row_vol_i,
    input  logic                                row_push_i,
    input  logic [2*NUM_CH-1:0]                 pop_i,
    input  mixer_pkg::sample_t                  data_i,
    input  logic                                lrck_i,
    input  logic                                we_i,
    output int                                  errors_o,
    output int                                  words_o
);

    import mixer_pkg::*;

    localparam int NSLOT = 2 * NUM_CH;
    localparam longint FULL_POS = (longint'(1) <<< (SAMPLE_W - 1)) - 1;
    localparam longint FULL_NEG = -(longint'(1) <<< (SAMPLE_W - 1));

    // Expected words in output order, lrck in the top bit
    logic [SAMPLE_W:0] expect_q [$];

    int errors = 0;
    int words = 0;
    int pops_seen = 0;

    // Volume is a fraction of 2^16
    function automatic longint scale(input sample_t s, input vol_t v);
        longint prod;
        prod = longint'(s) * longint'(v);
        return prod >>> VOL_W;
    endfunction

    function automatic longint clamp(input longint x);
        if (x > FULL_POS) begin
            return FULL_POS;
        end
        if (x < FULL_NEG) begin
            return FULL_NEG;
        end
        return x;
    endfunction

    // Slots are summed in ascending order, clamped after each add
    task automatic queue_row();
        longint left;
        longint right;
        int k;
        left = 0;
        right = 0;
        for (k = 0; k < NSLOT; k++) begin
            if (k % 2 == 0) begin
                left = clamp(left + scale(row_data_i[k], row_vol_i[k]));
            end else begin
                right = clamp(right + scale(row_data_i[k], row_vol_i[k]));
            end
        end
        expect_q.push_back({1'b0, left[SAMPLE_W-1:0]});
        expect_q.push_back({1'b1, right[SAMPLE_W-1:0]});
    endtask

    task automatic check_pop();
        logic [NSLOT-1:0] expected;
        if (pops_seen >= NSLOT) begin
            $display("More than %0d pop strobes in frame %0d", NSLOT, words / 2);
            errors++;
        end else begin
            expected = NSLOT'(1) << pops_seen;
            if (pop_i !== expected) begin
                $display("[FAIL] frame%0d_pop_order: expected %b actual %b",
                         words / 2, expected, pop_i);
                errors++;
            end
        end
        pops_seen++;
    endtask

    task automatic check_word();
        logic [SAMPLE_W:0] entry;
        string name;
        if (expect_q.size() == 0) begin
            $display("Write strobe at %0t with no expected word queued", $time);
            errors++;
        end else begin
            entry = expect_q.pop_front();
            name = $sformatf("frame%0d_%s", words / 2, entry[SAMPLE_W] ? "right" : "left");
            if (data_i !== entry[SAMPLE_W-1:0]) begin
                $display("[FAIL] %s data: expected %06h actual %06h",
                         name, entry[SAMPLE_W-1:0], data_i);
                errors++;
            end
            if (lrck_i !== entry[SAMPLE_W]) begin
                $display("[FAIL] %s lrck: expected %0b actual %0b", name, entry[SAMPLE_W], lrck_i);
                errors++;
            end
            // All pops of a frame are done before its left word
            if (!entry[SAMPLE_W]) begin
                if (pops_seen != NSLOT) begin
                    $display("[FAIL] %s pop_count: expected %0d actual %0d",
                             name, NSLOT, pops_seen);
                    errors++;
                end
                pops_seen = 0;
            end
        end
        words++;
    endtask

    always @(posedge clk) begin
        if (row_push_i) begin
            queue_row();
        end
        if (!rst) begin
            if (pop_i != '0) begin
                check_pop();
            end
            if (we_i) begin
                check_word();
            end
        end
    end

    assign errors_o = errors;
    assign words_o  = words;

endmodule

/* verif/mixer_checker.sv */
`timescale 1ns/1ps

module mixer_checker #(
    parameter int NUM_CH = 2
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [2*NUM_CH-1:0] pop_i,
    input  logic                we_i,
    input  logic                lrck_i
);

    // Failed assertions, read back at the end of the run
    int fail_count = 0;

    we_single: assert property (@(posedge clk) disable iff (rst) we_i |=> !we_i)
        else begin
            $error("we_o stayed high for two cycles");
            fail_count++;
        end

    pop_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(pop_i))
        else begin
            $error("pop_o has more than one bit set");
            fail_count++;
        end

    // LR clock moves only with a new word
    lrck_with_we: assert property (@(posedge clk) disable iff (rst) !$stable(lrck_i) |-> we_i)
        else begin
            $error("lrck_o changed without a write strobe");
            fail_count++;
        end

    quiet_in_reset: assert property (@(posedge clk) rst |=> (pop_i == '0 && !we_i && !lrck_i))
        else begin
            $error("Outputs not cleared during or right after reset");
            fail_count++;
        end

endmodule

/* hw/audio_mixer_top.sv */
`timescale 1ns/1ps

module audio_mixer_top #(
    parameter int NUM_CH = 2,
    parameter int FS     = 32
) (
    input  logic                                clk,
    input  logic                                rst,
    input  mixer_pkg::sample_t [2*NUM_CH-1:0]   data_i,
    input  mixer_pkg::vol_t    [2*NUM_CH-1:0]   vol_i,
    output logic [2*NUM_CH-1:0]                 pop_o,
    output mixer_pkg::sample_t                  data_o,
    output logic                                lrck_o,
    output logic                                we_o
);

    import mixer_pkg::*;

    localparam int SLOT_W = $clog2(2 * NUM_CH);

    // Sequencer to MAC
    logic [SLOT_W-1:0] slot_sel;
    logic              slot_valid;
    logic              acc_clear;

    // Sequencer to output stage
    logic latch_left;
    logic latch_right;

    // MAC to output stage
    sample_t sum_left;
    sample_t sum_right;

    mix_sequencer #(
        .NUM_CH (NUM_CH),
        .FS     (FS)
    ) u_seq (
        .clk           (clk),
        .rst           (rst),
        .slot_sel_o    (slot_sel),
        .slot_valid_o  (slot_valid),
        .pop_o         (pop_o),
        .acc_clear_o   (acc_clear),
        .latch_left_o  (latch_left),
        .latch_right_o (latch_right)
    );

    mix_mac #(
        .NUM_CH (NUM_CH)
    ) u_mac (
        .clk          (clk),
        .rst          (rst),
        .data_i       (data_i),
        .vol_i        (vol_i),
        .slot_sel_i   (slot_sel),
        .slot_valid_i (slot_valid),
        .acc_clear_i  (acc_clear),
        .sum_left_o   (sum_left),
        .sum_right_o  (sum_right)
    );

    mix_output u_out (
        .clk           (clk),
        .rst           (rst),
        .sum_left_i    (sum_left),
        .sum_right_i   (sum_right),
        .latch_left_i  (latch_left),
        .latch_right_i (latch_right),
        .data_o        (data_o),
        .lrck_o        (lrck_o),
        .we_o          (we_o)
    );

endmodule

/* hw/mix_output.sv */
`timescale 1ns/1ps

module mix_output (
    input  logic                clk,
    input  logic                rst,
    input  mixer_pkg::sample_t  sum_left_i,
    input  mixer_pkg::sample_t  sum_right_i,
    input  logic                latch_left_i,
    input  logic                latch_right_i,
    output mixer_pkg::sample_t  data_o,
    output logic                lrck_o,
    output logic                we_o
);

    logic [$bits(data_o)-1:0] data_q;
    logic                     lrck_q;
    logic                     we_q;

    // Output word, only updated on a latch
    always_ff @(posedge clk) begin
        if (rst) begin
            data_q <= '0;
        end else if (latch_left_i) begin
            data_q <= sum_left_i;
        end else if (latch_right_i) begin
            data_q <= sum_right_i;
        end
    end

    // LR clock level, 0 while the left word is out
    always_ff @(posedge clk) begin
        if (rst) begin
            lrck_q <= 1'b0;
        end else if (latch_left_i) begin
            lrck_q <= 1'b0;
        end else if (latch_right_i) begin
            lrck_q <= 1'b1;
        end
    end

    // Single cycle write strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            we_q <= 1'b0;
        end else begin
            we_q <= latch_left_i | latch_right_i;
        end
    end

    assign data_o = data_q;
    assign lrck_o = lrck_q;
    assign we_o   = we_q;

endmodule

/* hw/mix_mac.sv */
`timescale 1ns/1ps

module mix_mac #(
    parameter int NUM_CH = 2
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  mixer_pkg::sample_t [2*NUM_CH-1:0]       data_i,
    input  mixer_pkg::vol_t    [2*NUM_CH-1:0]       vol_i,
    input  logic [$clog2(2*NUM_CH)-1:0]             slot_sel_i,
    input  logic                                    slot_valid_i,
    input  logic                                    acc_clear_i,
    output mixer_pkg::sample_t                      sum_left_o,
    output mixer_pkg::sample_t                      sum_right_o
);

    import mixer_pkg::*;

    // Add two samples and clamp to full scale
    function automatic sample_t sat_add(input sample_t a, input sample_t b);
        logic signed [SAMPLE_W:0] wide;
        wide = a + b;
        if (wide > SAMPLE_MAX) begin
            return SAMPLE_MAX;
        end else if (wide < SAMPLE_MIN) begin
            return SAMPLE_MIN;
        end
        return wide[SAMPLE_W-1:0];
    endfunction

    // Stage 1 registers
    sample_t s1_data;
    vol_t    s1_vol;
    logic    s1_valid;
    logic    s1_right;

    // Stage 2 registers
    sample_t s2_scaled;
    logic    s2_valid;
    logic    s2_right;

    logic signed [PROD_W-1:0] prod;
    logic signed [PROD_W-1:0] prod_shift;

    sample_t sum_left;
    sample_t sum_right;

    // Stage 1: pick the selected slot
    always_ff @(posedge clk) begin
        if (slot_valid_i) begin
            s1_data <= data_i[slot_sel_i];
            s1_vol  <= vol_i[slot_sel_i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s1_right <= 1'b0;
        end else begin
            s1_valid <= slot_valid_i;
            // Odd slots are right channels
            s1_right <= slot_sel_i[0];
        end
    end

    // Volume is unsigned, so extend with a zero before the signed multiply
    assign prod       = s1_data * $signed({1'b0, s1_vol});
    assign prod_shift = prod >>> VOL_W;

    // Stage 2: scaled sample, always fits the sample width
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            s2_scaled <= prod_shift[SAMPLE_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s2_valid <= 1'b0;
            s2_right <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
            s2_right <= s1_right;
        end
    end

    // Stage 3: saturating accumulate into one side
    always_ff @(posedge clk) begin
        if (rst || acc_clear_i) begin
            sum_left  <= '0;
            sum_right <= '0;
        end else if (s2_valid) begin
            if (s2_right) begin
                sum_right <= sat_add(sum_right, s2_scaled);
            end else begin
                sum_left <= sat_add(sum_left, s2_scaled);
            end
        end
    end

    assign sum_left_o  = sum_left;
    assign sum_right_o = sum_right;

endmodule

/* hw/mix_sequencer.sv */
`timescale 1ns/1ps

module mix_sequencer #(
    parameter int NUM_CH = 2,
    parameter int FS     = 32
) (
    input  logic                          clk,
    input  logic                          rst,
    output logic [$clog2(2*NUM_CH)-1:0]   slot_sel_o,
    output logic                          slot_valid_o,
    output logic [2*NUM_CH-1:0]           pop_o,
    output logic                          acc_clear_o,
    output logic                          latch_left_o,
    output logic                          latch_right_o
);

    localparam int NSLOT   = 2 * NUM_CH;
    localparam int SLOT_W  = $clog2(NSLOT);
    localparam int PHASE_W = $clog2(FS);

    // Phases where the output stage grabs each finished sum
    localparam logic [PHASE_W-1:0] LATCH_L_PHASE = PHASE_W'(FS / 2 - 1);
    localparam logic [PHASE_W-1:0] LATCH_R_PHASE = PHASE_W'(FS - 1);

    logic [PHASE_W-1:0] phase;
    logic [NSLOT-1:0]   pop_q;
    logic [NSLOT-1:0]   pop_next;
    logic               slot_valid;

    // Frame phase counter, wraps naturally since FS is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= '0;
        end else begin
            phase <= phase + 1'b1;
        end
    end

    // Slot phases come first in the frame
    assign slot_valid = (phase < PHASE_W'(NSLOT));

    assign slot_valid_o = slot_valid;
    assign slot_sel_o   = phase[SLOT_W-1:0];

    // Clear lands at end of phase 0, first add at end of phase 2
    assign acc_clear_o = (phase == '0);

    assign latch_left_o  = (phase == LATCH_L_PHASE);
    assign latch_right_o = (phase == LATCH_R_PHASE);

    // One-hot of the slot being captured this phase
    always_comb begin
        pop_next = '0;
        if (slot_valid) begin
            pop_next = NSLOT'(1) << phase[SLOT_W-1:0];
        end
    end

    // Pop trails the selection by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            pop_q <= '0;
        end else begin
            pop_q <= pop_next;
        end
    end

    assign pop_o = pop_q;

endmodule

/* hw/mixer_pkg.sv */
package mixer_pkg;

    // Audio word and volume widths
    localparam int SAMPLE_W = 24;
    localparam int VOL_W    = 16;

    // Full signed sample times unsigned volume
    localparam int PROD_W = SAMPLE_W + VOL_W;

    // Signed audio sample
    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // Volume as an unsigned fraction, FFFF just under unity
    typedef logic [VOL_W-1:0] vol_t;

    // Clamp limits for the mix sums
    localparam sample_t SAMPLE_MAX = sample_t'({1'b0, {(SAMPLE_W-1){1'b1}}});
    localparam sample_t SAMPLE_MIN = sample_t'({1'b1, {(SAMPLE_W-1){1'b0}}});

endpackage
